// File: verif/fpu_stim.txt
// op rs1 rs2 expected, all hex; op follows fpu_op_e (1 FADD .. e FMVWX)
04 3f800000 bf800000 bf800000
05 3f800000 bf800000 3f800000
06 c0000000 bf800000 40000000
0d 12345678 00000000 12345678
0e deadbeef 00000000 deadbeef
0c ff800000 00000000 00000001
09 00000000 80000000 00000001
0a bf800000 3f800000 00000001
0b 00000001 00000000 00000001
07 c0400000 bf800000 c0400000
08 3f800000 40400000 40400000
01 3f800000 40000000 40400000
01 bf800000 3f000000 bf000000
02 40400000 3f800000 40000000
02 3f800000 3f800000 00000000
03 40000000 40400000 40c00000
03 3f800001 3f800001 3f800002
03 00400000 c0000000 80000000
03 00800000 00800000 00000000

// File: build.f
+incdir+common
common/fpu_op_pkg.sv
common/fpu_float_pkg.sv
source/fpu_decoder.sv
sequencer/fpu_microcode.sv
datapath/fpu_clz.sv
datapath/fpu_datapath.sv
source/fpu_top.sv
verif/fpu_checker.sv
verif/fpu_monitor.sv
verif/fpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fpu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/fpu_tb.sv
//////////////////////////////
// FPU testbench, reads verif/fpu_stim.txt and drives one
// op per line, the monitor compares each result
//////////////////////////////
`timescale 1ns/1ps

module fpu_tb;
   import fpu_op_pkg::*;
   import fpu_float_pkg::*;

   localparam int MAX_TESTS = 64;
   localparam int WORDS     = 4;            // op, rs1, rs2, expected

   logic        clk;
   logic        rst;
   logic        wr;
   logic        busy;
   logic [31:2] instr;
   fp_word_u    rs1, rs2, out;
   fp_word_u    exp_out;                    // Expected result for the monitor
   logic [4:0]  exp_op;
   int          errors, checks;
   int          n_tests;
   int          cycles = 0;
   int          timeout_limit = 0;
   logic [31:0] stim_mem [0:MAX_TESTS*WORDS-1];

   fpu_top u_dut (
      .clk   (clk),
      .rst   (rst),
      .wr    (wr),
      .instr (instr),
      .rs1   (rs1),
      .rs2   (rs2),
      .busy  (busy),
      .out   (out)
   );

   fpu_monitor u_monitor (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr),
      .busy    (busy),
      .out     (out),
      .exp_out (exp_out),
      .exp_op  (exp_op),
      .errors  (errors),
      .checks  (checks)
   );

   // OP-FP encoding from the RV32F tables, fields are {funct5, rm, rs2}
   function automatic logic [31:2] encode_instr(input logic [4:0] code);
      logic [12:0] fields;
      case (fpu_op_e'(code))
         OP_FADD:   fields = {5'b00000, 3'b001, 5'd2};   // rm = RTZ
         OP_FSUB:   fields = {5'b00001, 3'b001, 5'd2};
         OP_FMUL:   fields = {5'b00010, 3'b001, 5'd2};
         OP_FSGNJ:  fields = {5'b00100, 3'b000, 5'd2};
         OP_FSGNJN: fields = {5'b00100, 3'b001, 5'd2};
         OP_FSGNJX: fields = {5'b00100, 3'b010, 5'd2};
         OP_FMIN:   fields = {5'b00101, 3'b000, 5'd2};
         OP_FMAX:   fields = {5'b00101, 3'b001, 5'd2};
         OP_FEQ:    fields = {5'b10100, 3'b010, 5'd2};
         OP_FLT:    fields = {5'b10100, 3'b001, 5'd2};
         OP_FLE:    fields = {5'b10100, 3'b000, 5'd2};
         OP_FCLASS: fields = {5'b11100, 3'b001, 5'd0};
         OP_FMVXW:  fields = {5'b11100, 3'b000, 5'd0};
         OP_FMVWX:  fields = {5'b11110, 3'b000, 5'd0};
         default:   fields = {5'b11111, 3'b000, 5'd0};   // Not an F op
      endcase
      // funct5, fmt S, rs2, rs1 = f1, rm, rd = f3, OP-FP
      return {fields[12:8], 2'b00, fields[4:0], 5'd1, fields[7:5], 5'd3, 5'b10100};
   endfunction

   // One stim line: strobe wr, then wait for busy to drop
   task automatic apply_test(input int t);
      logic [31:0] code_w;
      code_w = stim_mem[t*WORDS];
      @(posedge clk);
      #1;
      wr           = 1'b1;
      instr        = encode_instr(code_w[4:0]);
      rs1.bits     = stim_mem[t*WORDS+1];
      rs2.bits     = stim_mem[t*WORDS+2];
      exp_out.bits = stim_mem[t*WORDS+3];
      exp_op       = code_w[4:0];
      @(posedge clk);
      #1;
      wr = 1'b0;
      while (busy) begin
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                 // 10 ns period
   end

   // Run limit from the number of stim lines
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (timeout_limit > 0 && cycles >= timeout_limit) begin
         $display("Timeout: tests still running after %0d cycles", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      rst          = 1'b1;
      wr           = 1'b0;
      instr        = '0;
      rs1          = '0;
      rs2          = '0;
      exp_out      = '0;
      exp_op       = '0;
      for (int i = 0; i < MAX_TESTS*WORDS; i++) begin
         stim_mem[i] = 32'hA5A5_0000 | 32'(i);   // Marks words past the file end
      end
      $readmemh("verif/fpu_stim.txt", stim_mem);
      n_tests = 0;
      while (n_tests < MAX_TESTS && stim_mem[n_tests*WORDS][31:8] == '0) begin
         n_tests++;
      end
      timeout_limit = 12 * n_tests + 20;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int t = 0; t < n_tests; t++) begin
         apply_test(t);
      end
      repeat (2) @(posedge clk);             // Let the monitor see the last result
      #1;
      if (n_tests == 0) $display("No tests were read from the stim file");
      if (checks != n_tests) $display("Some tests never produced a checked result");
      $display("Checks: %0d of %0d, errors: %0d, assertion failures: %0d",
               checks, n_tests, errors, u_dut.u_checker.fails);
      if (n_tests > 0 && checks == n_tests && errors == 0 && u_dut.u_checker.fails == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: verif/fpu_monitor.sv
//////////////////////////////
// Result monitor, latches the expected value at wr and
// compares out and the busy length once busy is low again
//////////////////////////////
`timescale 1ns/1ps

module fpu_monitor (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr,
   input  logic                    busy,
   input  fpu_float_pkg::fp_word_u out,
   input  fpu_float_pkg::fp_word_u exp_out,
   input  logic [4:0]              exp_op,
   output int                      errors,
   output int                      checks
);
   import fpu_op_pkg::*;
   import fpu_float_pkg::*;

   fp_word_u   want;                         // Expected value of the pending op
   logic [4:0] want_op;
   logic       pending;                      // An op is in flight
   int         busy_seen;                    // Edges with busy high since wr

   // Busy cycles of each program, zero for single-cycle ops
   function automatic int busy_len(input logic [4:0] code);
      case (fpu_op_e'(code))
         OP_FMUL:                                  return 1;
         OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX: return 2;
         OP_FADD, OP_FSUB:                         return 5;
         default:                                  return 0;
      endcase
   endfunction

   always @(posedge clk) begin
      int bad;                                 // Errors found at this edge
      bad = 0;
      if (rst) begin
         pending   <= 1'b0;
         errors    <= 0;
         checks    <= 0;
         want      <= '0;
         want_op   <= '0;
         busy_seen <= 0;
      end else begin
         if (pending && busy) busy_seen <= busy_seen + 1;
         // First edge with busy low after wr, out holds the result
         if (pending && !busy) begin
            checks  <= checks + 1;
            pending <= 1'b0;
            if (out !== want) begin
               bad++;
               $display("FAILED t=%0t out: got %h, expected %h (op %0d)",
                        $time, out.bits, want.bits, want_op);
            end
            if (busy_seen != busy_len(want_op)) begin
               bad++;
               $display("FAILED t=%0t busy cycles: got %0d, expected %0d (op %0d)",
                        $time, busy_seen, busy_len(want_op), want_op);
            end
         end
         if (wr) begin
            if (pending && busy) begin
               bad++;
               $display("New op started at t=%0t before the previous result", $time);
            end
            pending   <= 1'b1;
            busy_seen <= 0;
            want      <= exp_out;
            want_op   <= exp_op;
         end
         errors <= errors + bad;
      end
   end

endmodule

// File: verif/fpu_checker.sv
//////////////////////////////
// Protocol assertions, bound into fpu_top
//////////////////////////////
`timescale 1ns/1ps

module fpu_checker (
   input logic                clk,
   input logic                rst,
   input logic                wr,
   input logic                busy,
   input fpu_op_pkg::fpu_op_e op
);
   import fpu_op_pkg::*;

   localparam int MAX_BUSY = 5;              // Longest program, FADD/FSUB

   int   fails = 0;                          // Failed assertions so far
   int   busy_run;                           // Consecutive busy cycles
   logic multi_op;

   assign multi_op = op inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FMIN, OP_FMAX,
                                OP_FEQ, OP_FLT, OP_FLE};

   always @(posedge clk) begin
      if (rst || !busy) busy_run <= 0;
      else              busy_run <= busy_run + 1;
   end

   a_reset_idle: assert property (@(posedge clk) rst |=> !busy)
      else begin $error("busy high after reset"); fails++; end

   a_wr_idle: assert property (@(posedge clk) disable iff (rst) !(wr && busy))
      else begin $error("wr raised while busy"); fails++; end

   a_busy_bound: assert property (@(posedge clk) disable iff (rst) busy_run <= MAX_BUSY)
      else begin $error("busy held past the longest program"); fails++; end

   a_single_idle: assert property (@(posedge clk) disable iff (rst) (wr && !multi_op) |=> !busy)
      else begin $error("single-cycle op raised busy"); fails++; end

endmodule

bind fpu_top fpu_checker u_checker (
   .clk  (clk),
   .rst  (rst),
   .wr   (wr),
   .busy (busy),
   .op   (op)
);

// File: source/fpu_top.sv
//////////////////////////////
// FPU top, decoder plus sequencer plus datapath
// Pulse wr with busy low, read out once busy is low
//////////////////////////////
`timescale 1ns/1ps

module fpu_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr,      // Start strobe
   input  logic [31:2]             instr,
   input  fpu_float_pkg::fp_word_u rs1,
   input  fpu_float_pkg::fp_word_u rs2,
   output logic                    busy,
   output fpu_float_pkg::fp_word_u out
);
   import fpu_op_pkg::*;

   fpu_op_e op;
   fpmi_t   uop;    // Current micro-instruction

   fpu_decoder u_decoder (
      .instr (instr),
      .op    (op)
   );

   fpu_microcode u_microcode (
      .clk  (clk),
      .rst  (rst),
      .wr   (wr),
      .op   (op),
      .uop  (uop),
      .busy (busy)
   );

   fpu_datapath u_datapath (
      .clk (clk),
      .rst (rst),
      .wr  (wr),
      .op  (op),
      .uop (uop),
      .rs1 (rs1),
      .rs2 (rs2),
      .out (out)
   );

endmodule

// File: datapath/fpu_datapath.sv
//////////////////////////////
// A/B operand and X/Y working registers, the single-cycle
// ops, comparator, adder, multiplier and normalization
// out is written on wr or by the last micro-op
//////////////////////////////
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_datapath (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr,
   input  fpu_op_pkg::fpu_op_e     op,
   input  fpu_op_pkg::fpmi_t       uop,
   input  fpu_float_pkg::fp_word_u rs1,
   input  fpu_float_pkg::fp_word_u rs2,
   output fpu_float_pkg::fp_word_u out
);
   import fpu_op_pkg::*;
   import fpu_float_pkg::*;

   localparam int CLZ_OFS = 63 - `FPU_NORM_BIT;   // clz of a normalized sum

   // Subnormals flush to zero
   function automatic float_t flush(input fp_word_u w);
      float_t r;
      r.sign = w.f.sign;
      r.exp  = w.f.exp;
      r.frac = (|w.f.exp) ? {1'b1, w.f.man} : '0;
      return r;
   endfunction

   function automatic fp_word_u pack(input wide_t w);
      fp_word_u r;
      r.f.sign = w.sign;
      r.f.exp  = w.exp[`FPU_EXP_W-1:0];
      r.f.man  = w.frac[`FPU_NORM_BIT-1 -: `FPU_MAN_W];
      return r;
   endfunction

   float_t          a, b;
   wide_t           x, y;
   wide_t           norm_res, mul_res;
   logic [5:0]      norm_lshamt;         // Left shift found at add_add
   logic signed [8:0] x_exp_norm;        // Exponent once normalized
   logic            inj_sign;
   logic [9:0]      fclass;
   logic            s1, exp_zero, exp_max, man_zero;

   // Comparator, shared by swap, cmp and min/max
   logic signed [8:0]  exp_diff;
   logic signed [50:0] frac_diff, frac_sum;
   logic exp_eq, frac_eq, fabs_eq, fabs_x_lt, fabs_y_lt, both_zero;
   logic x_lt_y, x_eq_y, x_le_y, cmp_bit;

   assign exp_diff  = $signed(y.exp) - $signed(x.exp);
   assign frac_diff = $signed(y.frac) - $signed(x.frac);
   assign frac_sum  = $signed(y.frac) + $signed(x.frac);
   assign exp_eq    = (exp_diff == '0);
   assign frac_eq   = (frac_diff == '0);
   assign fabs_eq   = exp_eq && frac_eq;
   assign fabs_x_lt = (!exp_diff[8] && !exp_eq) || (exp_eq && !frac_eq && !frac_diff[50]);
   assign fabs_y_lt = exp_diff[8] || (exp_eq && frac_diff[50]);
   assign both_zero = (x.frac == '0) && (y.frac == '0);   // +0 == -0

   assign x_eq_y = both_zero || (fabs_eq && (x.sign == y.sign));
   assign x_lt_y = !both_zero && ((x.sign && !y.sign) ||
                                  (x.sign && y.sign && fabs_y_lt) ||
                                  (!x.sign && !y.sign && fabs_x_lt));
   assign x_le_y = x_lt_y || x_eq_y;
   assign cmp_bit = ((op == OP_FLT) && x_lt_y) || ((op == OP_FLE) && x_le_y) ||
                    ((op == OP_FEQ) && x_eq_y);

   // Leading zeros of the sum, first bit set = 63 - clz
   logic [5:0] sum_clz;

   fpu_clz #(.W_IN(64)) u_clz (
      .in    ({13'b0, frac_sum}),
      .count (sum_clz)
   );

   // Truncated product, leading one at bit 47 or 46
   logic [`FPU_WIDE_W-1:0]   prod_frac;
   logic signed [9:0]        prod_exp;
   logic                     prod_z;

   assign prod_frac = a.frac * b.frac;
   assign prod_exp  = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp})
                      - $signed(10'(`FPU_BIAS)) + $signed({9'b0, prod_frac[`FPU_NORM_BIT]});
   assign prod_z    = (prod_exp <= 0) || !(|prod_frac[`FPU_NORM_BIT -: 2]);  // Zero or underflow

   always_comb begin
      mul_res.sign = a.sign ^ b.sign;                // Signed zero keeps the XOR
      mul_res.exp  = prod_z ? '0 : prod_exp[8:0];
      mul_res.frac = prod_z ? '0 : (prod_frac[`FPU_NORM_BIT] ? prod_frac : prod_frac << 1);
   end

   always_comb begin
      norm_res.sign = x.sign;
      norm_res.exp  = x_exp_norm;
      norm_res.frac = x.frac[48] ? (x.frac >> 1) : (x.frac << norm_lshamt);  // Carry out
      if (x_exp_norm <= 0 || x.frac == '0)
         norm_res = '0;                              // Cancellation or underflow gives +0
   end

   // Sign injection source
   always_comb begin
      case (op)
         OP_FSGNJN: inj_sign = ~rs2.f.sign;
         OP_FSGNJX: inj_sign = rs1.f.sign ^ rs2.f.sign;
         default:   inj_sign = rs2.f.sign;
      endcase
   end

   // FCLASS on the raw rs1 word
   assign s1       = rs1.bits[31];
   assign exp_zero = (rs1.bits[30:23] == '0);
   assign exp_max  = (rs1.bits[30:23] == '1);
   assign man_zero = (rs1.bits[22:0] == '0);
   assign fclass = {exp_max & rs1.bits[22],                  // Quiet NaN
                    exp_max & ~rs1.bits[22] & |rs1.bits[21:0],  // Signaling NaN
                    ~s1 & exp_max & man_zero,
                    ~s1 & ~exp_zero & ~exp_max,
                    ~s1 & exp_zero & ~man_zero,
                    ~s1 & exp_zero & man_zero,
                    s1 & exp_zero & man_zero,
                    s1 & exp_zero & ~man_zero,
                    s1 & ~exp_zero & ~exp_max,
                    s1 & exp_max & man_zero};                // -inf

   always_ff @(posedge clk) begin
      if (wr) begin
         a <= flush(rs1);
         b <= flush(rs2);
      end else begin
         case (uop.op)
            FPMI_LOAD_XY: begin
               x <= '{a.sign, {1'b0, a.exp}, `FPU_WIDE_W'(a.frac) << (`FPU_NORM_BIT - `FPU_MAN_W)};
               y <= '{b.sign ^ (op == OP_FSUB), {1'b0, b.exp},
                      `FPU_WIDE_W'(b.frac) << (`FPU_NORM_BIT - `FPU_MAN_W)};
            end
            FPMI_LOAD_XY_MUL: x <= mul_res;
            FPMI_ADD_SWAP: begin
               if (fabs_y_lt) begin                  // Y always ends up the larger
                  x      <= y;
                  x.frac <= (x.sign ^ y.sign) ? -$signed(y.frac) : y.frac;
                  y      <= x;
               end else if (x.sign ^ y.sign) begin
                  x.frac <= -$signed(x.frac);
               end
            end
            FPMI_ADD_SHIFT: begin
               x.frac <= $signed(x.frac) >>> exp_diff;   // Sign kept for negated X
               x.exp  <= y.exp;
            end
            FPMI_ADD_ADD: begin
               x.frac      <= frac_sum[`FPU_WIDE_W-1:0];
               x.sign      <= y.sign;
               norm_lshamt <= sum_clz - 6'(CLZ_OFS);
               x_exp_norm  <= $signed(x.exp) + $signed(9'(CLZ_OFS)) - $signed({3'b000, sum_clz});
            end
            FPMI_ADD_NORM: x <= norm_res;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out <= '0;
      end else if (wr) begin
         case (op)
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: out.f <= '{inj_sign, rs1.f.exp, rs1.f.man};
            OP_FCLASS:                      out.bits <= {22'b0, fclass};
            OP_FMVXW, OP_FMVWX:             out <= rs1;
            default: ;                       // Multi-cycle ops write later
         endcase
      end else begin
         case (uop.op)
            FPMI_LOAD_XY_MUL: out <= pack(mul_res);
            FPMI_ADD_NORM:    out <= pack(norm_res);
            FPMI_CMP:         out.bits <= {31'b0, cmp_bit};
            FPMI_MIN_MAX:     out <= (x_lt_y ^ (op == OP_FMAX)) ? pack(x) : pack(y);
            default: ;
         endcase
      end
   end

endmodule

// File: datapath/fpu_clz.sv
//////////////////////////////
// Leading-zero counter, recursive halving
// W_IN must be a power of two, 2 or more
//////////////////////////////
`timescale 1ns/1ps

module fpu_clz #(
   parameter int W_IN = 64
) (
   input  logic [W_IN-1:0]         in,
   output logic [$clog2(W_IN)-1:0] count
);

   if (W_IN == 2) begin : g_leaf
      assign count = !in[1];
   end else begin : g_split
      logic [W_IN/2-1:0]       lhs, rhs;
      logic [$clog2(W_IN)-2:0] half_count;
      logic                    left_empty;

      assign lhs        = in[W_IN/2 +: W_IN/2];
      assign rhs        = in[0 +: W_IN/2];
      assign left_empty = ~|lhs;                    // MSB of the count at this level

      fpu_clz #(.W_IN(W_IN/2)) u_half (
         .in    (left_empty ? rhs : lhs),
         .count (half_count)
      );

      assign count = {left_empty, half_count};
   end

endmodule

// File: sequencer/fpu_microcode.sv
//////////////////////////////
// Micro-program ROM, micro-PC and busy flag
// wr jumps to the program of op, an exit word returns to 0
//////////////////////////////
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_microcode (
   input  logic                clk,
   input  logic                rst,
   input  logic                wr,
   input  fpu_op_pkg::fpu_op_e op,
   output fpu_op_pkg::fpmi_t   uop,
   output logic                busy
);
   import fpu_op_pkg::*;

   typedef fpmi_t [`FPU_ROM_DEPTH-1:0] rom_t;

   // Program entry points, word 0 is ready with exit
   localparam logic [`FPU_UPC_W-1:0] UPC_CMP     = `FPU_UPC_W'(1);
   localparam logic [`FPU_UPC_W-1:0] UPC_ADD     = `FPU_UPC_W'(3);
   localparam logic [`FPU_UPC_W-1:0] UPC_MUL     = `FPU_UPC_W'(8);
   localparam logic [`FPU_UPC_W-1:0] UPC_MIN_MAX = `FPU_UPC_W'(9);

   function automatic fpmi_t mi(input logic last, input fpmi_e code);
      fpmi_t w;
      w.exit_flag = last;
      w.op        = code;
      return w;
   endfunction

   function automatic rom_t build_rom();
      rom_t rom;
      for (int i = 0; i < `FPU_ROM_DEPTH; i++) begin
         rom[i] = mi(1'b1, FPMI_READY);         // Unused words park in ready
      end
      rom[UPC_CMP]     = mi(1'b0, FPMI_LOAD_XY);  // FEQ, FLT, FLE
      rom[UPC_CMP+1]   = mi(1'b1, FPMI_CMP);
      rom[UPC_ADD]     = mi(1'b0, FPMI_LOAD_XY);  // FADD, FSUB
      rom[UPC_ADD+1]   = mi(1'b0, FPMI_ADD_SWAP);
      rom[UPC_ADD+2]   = mi(1'b0, FPMI_ADD_SHIFT);
      rom[UPC_ADD+3]   = mi(1'b0, FPMI_ADD_ADD);
      rom[UPC_ADD+4]   = mi(1'b1, FPMI_ADD_NORM);
      rom[UPC_MUL]     = mi(1'b1, FPMI_LOAD_XY_MUL);
      rom[UPC_MIN_MAX] = mi(1'b0, FPMI_LOAD_XY);  // FMIN, FMAX
      rom[UPC_MIN_MAX+1] = mi(1'b1, FPMI_MIN_MAX);
      return rom;
   endfunction

   localparam rom_t ROM = build_rom();

   logic [`FPU_UPC_W-1:0] upc;
   logic [`FPU_UPC_W-1:0] start_addr;
   logic [`FPU_UPC_W-1:0] upc_next;

   always_comb begin
      case (op)
         OP_FEQ, OP_FLT, OP_FLE: start_addr = UPC_CMP;
         OP_FADD, OP_FSUB:       start_addr = UPC_ADD;
         OP_FMUL:                start_addr = UPC_MUL;
         OP_FMIN, OP_FMAX:       start_addr = UPC_MIN_MAX;
         default:                start_addr = '0;   // Single-cycle, stay ready
      endcase
   end

   assign upc_next = wr            ? start_addr :
                     uop.exit_flag ? '0         :
                                     upc + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         upc <= '0;
         uop <= ROM[0];
      end else begin
         upc <= upc_next;
         uop <= ROM[upc_next];    // Registered micro-op drives the datapath
      end
   end

   assign busy = (uop.op != FPMI_READY);

endmodule

// File: source/fpu_decoder.sv
//////////////////////////////
// RV32F decoder, maps instr[31:2] to one operation code
// Fused and conversion encodings give OP_NONE
//////////////////////////////
`timescale 1ns/1ps

module fpu_decoder (
   input  logic [31:2]         instr,
   output fpu_op_pkg::fpu_op_e op
);
   import fpu_op_pkg::*;

   logic [4:0] funct5;
   logic [1:0] fmt;
   logic [4:0] rs2_field;
   logic [2:0] rm;
   logic       is_op_fp;

   assign funct5    = instr[31:27];
   assign fmt       = instr[26:25];    // 00 is single precision
   assign rs2_field = instr[24:20];
   assign rm        = instr[14:12];    // Rounding mode or sub-function

   // OP-FP major opcode 1010011, fused ops have bit 4 clear
   assign is_op_fp = (instr[6:2] == 5'b10100) && (fmt == 2'b00);

   always_comb begin
      op = OP_NONE;
      if (is_op_fp) begin
         case (funct5)
            5'b00000: op = OP_FADD;    // Rounding mode ignored, always RTZ
            5'b00001: op = OP_FSUB;
            5'b00010: op = OP_FMUL;
            5'b00100: begin
               if (rm == 3'b000)      op = OP_FSGNJ;
               else if (rm == 3'b001) op = OP_FSGNJN;
               else if (rm == 3'b010) op = OP_FSGNJX;
            end
            5'b00101: begin
               if (rm == 3'b000)      op = OP_FMIN;
               else if (rm == 3'b001) op = OP_FMAX;
            end
            5'b10100: begin
               if (rm == 3'b010)      op = OP_FEQ;
               else if (rm == 3'b001) op = OP_FLT;
               else if (rm == 3'b000) op = OP_FLE;
            end
            // FMV.X.W and FCLASS share funct5, bit 12 tells them apart
            5'b11100: begin
               if (rs2_field == '0 && rm == 3'b000)      op = OP_FMVXW;
               else if (rs2_field == '0 && rm == 3'b001) op = OP_FCLASS;
            end
            5'b11110: begin
               if (rs2_field == '0 && rm == 3'b000) op = OP_FMVWX;
            end
            default: op = OP_NONE;     // FDIV, FSQRT and FCVT not built
         endcase
      end
   end

endmodule

// File: common/fpu_float_pkg.sv
//////////////////////////////
// Number side of the FPU: float fields, the operand
// word and the wide X/Y working registers
//////////////////////////////
`include "fpu_defines.svh"

package fpu_float_pkg;

   // Unpacked float, hidden bit made explicit
   typedef struct packed {
      logic                   sign;
      logic [`FPU_EXP_W-1:0]  exp;
      logic [`FPU_FRAC_W-1:0] frac;
   } float_t;

   // IEEE-754 single layout
   typedef struct packed {
      logic                  sign;
      logic [`FPU_EXP_W-1:0] exp;
      logic [`FPU_MAN_W-1:0] man;
   } fp_fields_t;

   // Operand word, seen as raw bits or as fields
   typedef union packed {
      logic [`FPU_EXP_W+`FPU_MAN_W:0] bits;
      fp_fields_t                     f;
   } fp_word_u;

   // X/Y register, leading one at bit 47 when normalized
   typedef struct packed {
      logic                          sign;
      logic signed [`FPU_EXP_W:0]    exp;   // One spare bit for under/overflow
      logic signed [`FPU_WIDE_W-1:0] frac;  // Two's complement during adds
   } wide_t;

endpackage

// File: common/fpu_op_pkg.sv
//////////////////////////////
// Operation side of the FPU: decoded instruction codes
// and the micro-instruction format run by the sequencer
//////////////////////////////
package fpu_op_pkg;

   // Decoded RV32F operation, the stim file uses the same codes
   typedef enum logic [4:0] {
      OP_NONE   = 5'd0,
      OP_FADD   = 5'd1,
      OP_FSUB   = 5'd2,
      OP_FMUL   = 5'd3,
      OP_FSGNJ  = 5'd4,
      OP_FSGNJN = 5'd5,
      OP_FSGNJX = 5'd6,
      OP_FMIN   = 5'd7,
      OP_FMAX   = 5'd8,
      OP_FEQ    = 5'd9,
      OP_FLT    = 5'd10,
      OP_FLE    = 5'd11,
      OP_FCLASS = 5'd12,
      OP_FMVXW  = 5'd13,
      OP_FMVWX  = 5'd14
   } fpu_op_e;

   typedef enum logic [3:0] {
      FPMI_READY       = 4'd0,  // Idle, busy low
      FPMI_LOAD_XY     = 4'd1,  // X <- A, Y <- B
      FPMI_LOAD_XY_MUL = 4'd2,  // X <- norm(A*B)
      FPMI_ADD_SWAP    = 4'd3,  // Smaller magnitude into X
      FPMI_ADD_SHIFT   = 4'd4,  // Align X to Y exponent
      FPMI_ADD_ADD     = 4'd5,  // X <- X + Y
      FPMI_ADD_NORM    = 4'd6,  // X <- norm(X)
      FPMI_CMP         = 4'd7,  // out <- X ? Y
      FPMI_MIN_MAX     = 4'd8   // out <- min/max(X,Y)
   } fpmi_e;

   typedef struct packed {
      logic  exit_flag;  // Last word of a program
      fpmi_e op;
   } fpmi_t;

endpackage

// File: common/fpu_defines.svh
//////////////////////////////
// Field widths, datapath width, micro-ROM size and bias
// for the FPU; include it wherever a width is needed
//////////////////////////////
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Single-precision float fields
`define FPU_EXP_W     8     // Biased exponent
`define FPU_MAN_W     23    // Stored fraction
`define FPU_FRAC_W    24    // Fraction with hidden bit
`define FPU_BIAS      127

// Wide X/Y registers, value = frac * 2^(exp - 127 - 47)
`define FPU_WIDE_W    50
`define FPU_NORM_BIT  47    // Leading one of a normalized X/Y fraction

// Micro-program store
`define FPU_ROM_DEPTH 16
`define FPU_UPC_W     4

`endif
